// File: include/game_settings.svh
`ifndef GAME_SETTINGS_SVH
`define GAME_SETTINGS_SVH

// box sizes in pixels
`define PLAYER_W 8
`define PLAYER_H 8
`define BLOCK_W 16
`define BLOCK_H 16
`define ITEM_W 8

`define NUM_BLOCKS 6
`define NUM_SNOW 3
`define NUM_MONSTERS 1

// entry 0 sits in the lowest bits
// floor of blocks 0..4 at y 200, block 5 is the wall
`define BLOCK_X_TABLE {10'd80, 10'd64, 10'd48, 10'd32, 10'd16, 10'd0}
`define BLOCK_Y_TABLE {9'd184, 9'd200, 9'd200, 9'd200, 9'd200, 9'd200}
`define SNOW_X_TABLE {10'd84, 10'd48, 10'd24}
`define SNOW_Y_TABLE {9'd176, 9'd192, 9'd192}
`define MON_X_TABLE {10'd40}
`define MON_Y_TABLE {9'd176}

`define START_X 4
`define START_Y 192

// periods in clock cycles per pixel
`define MOVE_PERIOD 4
`define RISE_PERIOD 3
`define FALL_START 6
`define FALL_MIN 2
`define FALL_STEP 1
`define FALL_BURST 4
`define JUMP_HEIGHT 20

`define HEALTH_MAX 3

// keyboard set 2 scan codes
`define KEY_A 8'h1C
`define KEY_D 8'h23
`define KEY_W 8'h1D
`define KEY_R 8'h2D
`define KEY_BREAK 8'hF0

`endif

// File: hdl/game_pkg.sv
package game_pkg;

    localparam int COORD_X_W = 10;
    localparam int COORD_Y_W = 9;

    // screen coordinates, origin at the top left
    typedef logic [COORD_X_W-1:0] coord_x_t;
    typedef logic [COORD_Y_W-1:0] coord_y_t;

    typedef enum logic [1:0] {
        GAME_IDLE = 2'b00,
        GAME_PLAY = 2'b01,
        GAME_WIN  = 2'b11,
        GAME_LOSE = 2'b10
    } game_state_e;

    // vertical phase of the player
    typedef enum logic [1:0] {
        MOVE_GROUND = 2'b00,
        MOVE_RISE   = 2'b01,
        MOVE_FALL   = 2'b10
    } motion_state_e;

endpackage

// File: hdl/key_decoder.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module key_decoder (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic [7:0] key_data_i,
    input  logic       key_valid_i,
    output logic       key_ready_o,
    output logic       left_o,
    output logic       right_o,
    output logic       jump_o,
    output logic       restart_o
);

    logic accept;
    logic break_seen;
    logic gap;

    // one dead cycle after every accepted byte
    assign key_ready_o = !gap;
    assign accept      = key_valid_i && key_ready_o;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gap        <= 1'b0;
            break_seen <= 1'b0;
            left_o     <= 1'b0;
            right_o    <= 1'b0;
            jump_o     <= 1'b0;
            restart_o  <= 1'b0;
        end else begin
            gap       <= accept;
            restart_o <= 1'b0;
            if (accept) begin
                if (key_data_i == `KEY_BREAK) begin
                    break_seen <= 1'b1;
                end else begin
                    // make sets the flag, break prefix clears it
                    break_seen <= 1'b0;
                    case (key_data_i)
                        `KEY_A: left_o  <= !break_seen;
                        `KEY_D: right_o <= !break_seen;
                        `KEY_W: jump_o  <= !break_seen;
                        `KEY_R: restart_o <= !break_seen;
                        default: ;
                    endcase
                end
            end
        end
    end

    // restart is a single-cycle event even when R repeats back to back
    restart_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n_i) restart_o |=> !restart_o
    );

endmodule

// File: hdl/level_map.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module level_map import game_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     level_reload_i,
    input  coord_x_t player_x_i,
    input  coord_y_t player_y_i,
    output logic     floor_o,
    output logic     ceiling_o,
    output logic     wall_right_o,
    output logic     wall_left_o,
    output logic     all_touched_o
);

    localparam logic [`NUM_BLOCKS*COORD_X_W-1:0] BLOCK_X = `BLOCK_X_TABLE;
    localparam logic [`NUM_BLOCKS*COORD_Y_W-1:0] BLOCK_Y = `BLOCK_Y_TABLE;

    int px;
    int py;
    logic [`NUM_BLOCKS-1:0] below;
    logic [`NUM_BLOCKS-1:0] above;
    logic [`NUM_BLOCKS-1:0] on_right;
    logic [`NUM_BLOCKS-1:0] on_left;
    logic [`NUM_BLOCKS-1:0] touched;

    assign px = int'(player_x_i);
    assign py = int'(player_y_i);

    generate
        for (genvar i = 0; i < `NUM_BLOCKS; i++) begin : g_block
            localparam int BX = int'(BLOCK_X[i*COORD_X_W +: COORD_X_W]);
            localparam int BY = int'(BLOCK_Y[i*COORD_Y_W +: COORD_Y_W]);
            logic x_span;
            logic y_span;

            // player columns or rows share some range with the block
            assign x_span = (px + `PLAYER_W > BX) && (px < BX + `BLOCK_W);
            assign y_span = (py + `PLAYER_H > BY) && (py < BY + `BLOCK_H);

            // row just under the player lies inside the block
            assign below[i] = x_span && (py + `PLAYER_H >= BY) &&
                              (py + `PLAYER_H < BY + `BLOCK_H);
            // row just above
            assign above[i] = x_span && (py > BY) && (py <= BY + `BLOCK_H);
            // column right of the box
            assign on_right[i] = y_span && (px + `PLAYER_W >= BX) &&
                                 (px + `PLAYER_W < BX + `BLOCK_W);
            assign on_left[i] = y_span && (px > BX) && (px <= BX + `BLOCK_W);
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            floor_o       <= 1'b0;
            ceiling_o     <= 1'b0;
            wall_right_o  <= 1'b0;
            wall_left_o   <= 1'b0;
            touched       <= '0;
            all_touched_o <= 1'b0;
        end else begin
            floor_o      <= |below;
            ceiling_o    <= |above;
            wall_right_o <= |on_right;
            wall_left_o  <= |on_left;
            if (level_reload_i) begin
                touched       <= '0;
                all_touched_o <= 1'b0;
            end else begin
                // a block counts once the player has stood on it
                touched       <= touched | below;
                all_touched_o <= &touched;
            end
        end
    end

endmodule

// File: hdl/player_motion.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module player_motion import game_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     play_en_i,
    input  logic     level_reload_i,
    input  logic     left_i,
    input  logic     right_i,
    input  logic     jump_i,
    input  logic     floor_i,
    input  logic     ceiling_i,
    input  logic     wall_right_i,
    input  logic     wall_left_i,
    output coord_x_t player_x_o,
    output coord_y_t player_y_o
);

    localparam int P_MAX0 = (`MOVE_PERIOD > `RISE_PERIOD) ? `MOVE_PERIOD : `RISE_PERIOD;
    localparam int P_MAX  = (P_MAX0 > `FALL_START) ? P_MAX0 : `FALL_START;
    localparam int PW     = $clog2(P_MAX + 1);
    localparam int RW     = $clog2(`JUMP_HEIGHT + 1);
    localparam int BW     = $clog2(`FALL_BURST + 1);

    motion_state_e state;
    logic [PW-1:0] h_cnt;
    logic [PW-1:0] v_cnt;
    logic [PW-1:0] fall_period;
    logic [RW-1:0] rise_cnt;
    logic [BW-1:0] burst_cnt;
    logic          go_left;
    logic          go_right;

    // left has priority, x stops at the screen edge
    assign go_left  = play_en_i && left_i && !wall_left_i && (player_x_o != '0);
    assign go_right = play_en_i && !left_i && right_i && !wall_right_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state       <= MOVE_GROUND;
            player_x_o  <= coord_x_t'(`START_X);
            player_y_o  <= coord_y_t'(`START_Y);
            h_cnt       <= '0;
            v_cnt       <= '0;
            fall_period <= PW'(`FALL_START);
            rise_cnt    <= '0;
            burst_cnt   <= '0;
        end else if (level_reload_i) begin
            state       <= MOVE_GROUND;
            player_x_o  <= coord_x_t'(`START_X);
            player_y_o  <= coord_y_t'(`START_Y);
            h_cnt       <= '0;
            v_cnt       <= '0;
            fall_period <= PW'(`FALL_START);
            rise_cnt    <= '0;
            burst_cnt   <= '0;
        end else begin
            // walking
            if (go_left || go_right) begin
                if (h_cnt == PW'(`MOVE_PERIOD - 1)) begin
                    h_cnt      <= '0;
                    player_x_o <= go_left ? player_x_o - 1'b1 : player_x_o + 1'b1;
                end else begin
                    h_cnt <= h_cnt + 1'b1;
                end
            end else begin
                h_cnt <= '0;
            end

            case (state)
                MOVE_GROUND: begin
                    v_cnt       <= '0;
                    rise_cnt    <= '0;
                    burst_cnt   <= '0;
                    fall_period <= PW'(`FALL_START);
                    if (!floor_i) begin
                        state <= MOVE_FALL;
                    end else if (play_en_i && jump_i) begin
                        state <= MOVE_RISE;
                    end
                end
                MOVE_RISE: begin
                    if (ceiling_i || rise_cnt == RW'(`JUMP_HEIGHT)) begin
                        state <= MOVE_FALL;
                        v_cnt <= '0;
                    end else if (v_cnt == PW'(`RISE_PERIOD - 1)) begin
                        v_cnt      <= '0;
                        player_y_o <= player_y_o - 1'b1;
                        rise_cnt   <= rise_cnt + 1'b1;
                    end else begin
                        v_cnt <= v_cnt + 1'b1;
                    end
                end
                MOVE_FALL: begin
                    if (floor_i) begin
                        state <= MOVE_GROUND;
                        v_cnt <= '0;
                    end else if (v_cnt == fall_period - 1'b1) begin
                        v_cnt      <= '0;
                        player_y_o <= player_y_o + 1'b1;
                        // speed up after each burst of pixels
                        if (burst_cnt == BW'(`FALL_BURST - 1)) begin
                            burst_cnt <= '0;
                            if (fall_period >= PW'(`FALL_MIN + `FALL_STEP)) begin
                                fall_period <= fall_period - PW'(`FALL_STEP);
                            end else begin
                                fall_period <= PW'(`FALL_MIN);
                            end
                        end else begin
                            burst_cnt <= burst_cnt + 1'b1;
                        end
                    end else begin
                        v_cnt <= v_cnt + 1'b1;
                    end
                end
                default: state <= MOVE_GROUND;
            endcase
        end
    end

    // the registered wall flag from level_map must hold x back
    no_walk_into_wall: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wall_right_i && !level_reload_i) |=> (player_x_o <= $past(player_x_o))
    );

    no_fall_through_floor: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (state == MOVE_GROUND && floor_i) |=> (state != MOVE_FALL)
    );

endmodule

// File: hdl/pickup_tracker.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module pickup_tracker import game_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     level_reload_i,
    input  coord_x_t player_x_i,
    input  coord_y_t player_y_i,
    output logic     snow_hit_o,
    output logic     monster_hit_o
);

    localparam logic [`NUM_SNOW*COORD_X_W-1:0]     SNOW_X = `SNOW_X_TABLE;
    localparam logic [`NUM_SNOW*COORD_Y_W-1:0]     SNOW_Y = `SNOW_Y_TABLE;
    localparam logic [`NUM_MONSTERS*COORD_X_W-1:0] MON_X  = `MON_X_TABLE;
    localparam logic [`NUM_MONSTERS*COORD_Y_W-1:0] MON_Y  = `MON_Y_TABLE;

    logic [`NUM_SNOW-1:0]     snow_now;
    logic [`NUM_SNOW-1:0]     collected;
    logic [`NUM_MONSTERS-1:0] mon_now;
    logic [`NUM_MONSTERS-1:0] mon_prev;

    // player box against an item square
    function automatic logic overlap(coord_x_t px, coord_y_t py, int ix, int iy);
        int x;
        int y;
        x = int'(px);
        y = int'(py);
        return (x + `PLAYER_W > ix) && (x < ix + `ITEM_W) &&
               (y + `PLAYER_H > iy) && (y < iy + `ITEM_W);
    endfunction

    generate
        for (genvar i = 0; i < `NUM_SNOW; i++) begin : g_snow
            assign snow_now[i] = overlap(player_x_i, player_y_i,
                                         int'(SNOW_X[i*COORD_X_W +: COORD_X_W]),
                                         int'(SNOW_Y[i*COORD_Y_W +: COORD_Y_W]));
        end
        for (genvar j = 0; j < `NUM_MONSTERS; j++) begin : g_mon
            assign mon_now[j] = overlap(player_x_i, player_y_i,
                                        int'(MON_X[j*COORD_X_W +: COORD_X_W]),
                                        int'(MON_Y[j*COORD_Y_W +: COORD_Y_W]));
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            collected     <= '0;
            mon_prev      <= '0;
            snow_hit_o    <= 1'b0;
            monster_hit_o <= 1'b0;
        end else if (level_reload_i) begin
            collected     <= '0;
            mon_prev      <= '0;
            snow_hit_o    <= 1'b0;
            monster_hit_o <= 1'b0;
        end else begin
            collected  <= collected | snow_now;
            snow_hit_o <= |(snow_now & ~collected);
            // monster hurts again only after the player has left it
            mon_prev      <= mon_now;
            monster_hit_o <= |(mon_now & ~mon_prev);
        end
    end

endmodule

// File: hdl/game_status.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module game_status import game_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic        restart_i,
    input  logic        snow_hit_i,
    input  logic        monster_hit_i,
    input  logic        all_touched_i,
    output logic        level_reload_o,
    output logic        play_en_o,
    output logic [3:0]  score_o,
    output logic [3:0]  health_o,
    output game_state_e game_state_o
);

    assign play_en_o = (game_state_o == GAME_PLAY);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            game_state_o   <= GAME_IDLE;
            level_reload_o <= 1'b0;
            score_o        <= '0;
            health_o       <= 4'(`HEALTH_MAX);
        end else begin
            level_reload_o <= restart_i;
            if (level_reload_o) begin
                // fresh level from any state
                game_state_o <= GAME_PLAY;
                score_o      <= '0;
                health_o     <= 4'(`HEALTH_MAX);
            end else if (game_state_o == GAME_PLAY) begin
                if (snow_hit_i) begin
                    score_o <= score_o + 1'b1;
                end
                if (monster_hit_i && health_o != '0) begin
                    health_o <= health_o - 1'b1;
                end
                // loss wins over a finished map
                if (health_o == '0) begin
                    game_state_o <= GAME_LOSE;
                end else if (all_touched_i) begin
                    game_state_o <= GAME_WIN;
                end
            end
        end
    end

    health_in_range: assert property (
        @(posedge clk) disable iff (!rst_n_i) health_o <= 4'(`HEALTH_MAX)
    );

endmodule

// File: hdl/platform_game_top.sv
`timescale 1ns/1ps

module platform_game_top import game_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  logic [7:0]  key_data_i,
    input  logic        key_valid_i,
    output logic        key_ready_o,
    output coord_x_t    player_x_o,
    output coord_y_t    player_y_o,
    output logic [3:0]  score_o,
    output logic [3:0]  health_o,
    output game_state_e game_state_o
);

    logic left;
    logic right;
    logic jump;
    logic restart;
    logic level_reload;
    logic play_en;
    logic floor_hit;
    logic ceiling_hit;
    logic wall_right;
    logic wall_left;
    logic all_touched;
    logic snow_hit;
    logic monster_hit;

    key_decoder u_keys (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .key_data_i  (key_data_i),
        .key_valid_i (key_valid_i),
        .key_ready_o (key_ready_o),
        .left_o      (left),
        .right_o     (right),
        .jump_o      (jump),
        .restart_o   (restart)
    );

    level_map u_map (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .level_reload_i (level_reload),
        .player_x_i     (player_x_o),
        .player_y_i     (player_y_o),
        .floor_o        (floor_hit),
        .ceiling_o      (ceiling_hit),
        .wall_right_o   (wall_right),
        .wall_left_o    (wall_left),
        .all_touched_o  (all_touched)
    );

    player_motion u_motion (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .play_en_i      (play_en),
        .level_reload_i (level_reload),
        .left_i         (left),
        .right_i        (right),
        .jump_i         (jump),
        .floor_i        (floor_hit),
        .ceiling_i      (ceiling_hit),
        .wall_right_i   (wall_right),
        .wall_left_i    (wall_left),
        .player_x_o     (player_x_o),
        .player_y_o     (player_y_o)
    );

    pickup_tracker u_pickups (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .level_reload_i (level_reload),
        .player_x_i     (player_x_o),
        .player_y_i     (player_y_o),
        .snow_hit_o     (snow_hit),
        .monster_hit_o  (monster_hit)
    );

    game_status u_status (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .restart_i      (restart),
        .snow_hit_i     (snow_hit),
        .monster_hit_i  (monster_hit),
        .all_touched_i  (all_touched),
        .level_reload_o (level_reload),
        .play_en_o      (play_en),
        .score_o        (score_o),
        .health_o       (health_o),
        .game_state_o   (game_state_o)
    );

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk     = 1'b0;
        rst_n_o = 1'b0;
        // reset held for three rising edges
        repeat (3) @(posedge clk);
        #1 rst_n_o = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

// File: tests/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import game_pkg::*; (
    input  logic            clk,
    input  logic            check_i,
    input  logic [8*24-1:0] name_i,
    input  logic            check_x_i,
    input  int              exp_x_i,
    input  int              exp_y_i,
    input  int              exp_score_i,
    input  int              exp_health_i,
    input  game_state_e     exp_state_i,
    input  coord_x_t        player_x_i,
    input  coord_y_t        player_y_i,
    input  logic [3:0]      score_i,
    input  logic [3:0]      health_i,
    input  game_state_e     game_state_i,
    input  logic            key_valid_i,
    input  logic            key_ready_i,
    output int              err_count_o
);

    logic took_byte;

    initial err_count_o = 0;
    initial took_byte = 1'b0;

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        // ready is low only in the cycle right after a transfer
        if (key_ready_i != !took_byte) begin
            $display("ERR key_handshake: ready expected %0d, actual %0d",
                     !took_byte, key_ready_i);
            err_count_o = err_count_o + 1;
        end
        took_byte = key_valid_i && key_ready_i;
        if (check_i) begin
            if (check_x_i && int'(player_x_i) != exp_x_i) begin
                $display("ERR %0s: x expected %0d, actual %0d",
                         name_i, exp_x_i, player_x_i);
                err_count_o = err_count_o + 1;
            end
            if (int'(player_y_i) != exp_y_i) begin
                $display("ERR %0s: y expected %0d, actual %0d",
                         name_i, exp_y_i, player_y_i);
                err_count_o = err_count_o + 1;
            end
            if (int'(score_i) != exp_score_i) begin
                $display("ERR %0s: score expected %0d, actual %0d",
                         name_i, exp_score_i, score_i);
                err_count_o = err_count_o + 1;
            end
            if (int'(health_i) != exp_health_i) begin
                $display("ERR %0s: health expected %0d, actual %0d",
                         name_i, exp_health_i, health_i);
                err_count_o = err_count_o + 1;
            end
            if (game_state_i != exp_state_i) begin
                $display("ERR %0s: state expected %0s, actual %0s",
                         name_i, exp_state_i.name(), game_state_i.name());
                err_count_o = err_count_o + 1;
            end
        end
    end

endmodule

// File: tests/tb_top.sv
`timescale 1ns/1ps
`include "game_settings.svh"

module tb_top import game_pkg::*; ;

    localparam int NUM_ROWS = 16;
    localparam int XSKIP    = -1;
    localparam int XSAME    = -2;
    // cycles without any output change that count as settled
    localparam int SETTLE   = 16;

    logic clk;
    logic rst_n;
    logic [7:0] key_data;
    logic key_valid;
    logic key_ready;
    coord_x_t player_x;
    coord_y_t player_y;
    logic [3:0] score;
    logic [3:0] health;
    game_state_e game_state;

    // stimulus and expected values, one row per step
    logic [8*24-1:0] row_name [NUM_ROWS];
    logic [7:0] row_byte [NUM_ROWS][3];
    int row_nbytes [NUM_ROWS];
    int row_nfirst [NUM_ROWS];
    int row_stop_x [NUM_ROWS];
    int row_budget [NUM_ROWS];
    int row_x [NUM_ROWS];
    int row_y [NUM_ROWS];
    int row_score [NUM_ROWS];
    int row_health [NUM_ROWS];
    game_state_e row_state [NUM_ROWS];
    int row_count;

    logic check_req;
    logic [8*24-1:0] cur_name;
    logic cur_check_x;
    int cur_x;
    int cur_y;
    int cur_score;
    int cur_health;
    game_state_e cur_state;
    int cmp_errors;
    int other_errors;
    int cycles;
    int cycle_limit;
    integer seed;

    tb_clock u_clock (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    platform_game_top DUT (
        .clk          (clk),
        .rst_n_i      (rst_n),
        .key_data_i   (key_data),
        .key_valid_i  (key_valid),
        .key_ready_o  (key_ready),
        .player_x_o   (player_x),
        .player_y_o   (player_y),
        .score_o      (score),
        .health_o     (health),
        .game_state_o (game_state)
    );

    tb_checker u_checker (
        .clk          (clk),
        .check_i      (check_req),
        .name_i       (cur_name),
        .check_x_i    (cur_check_x),
        .exp_x_i      (cur_x),
        .exp_y_i      (cur_y),
        .exp_score_i  (cur_score),
        .exp_health_i (cur_health),
        .exp_state_i  (cur_state),
        .player_x_i   (player_x),
        .player_y_i   (player_y),
        .score_i      (score),
        .health_i     (health),
        .game_state_i (game_state),
        .key_valid_i  (key_valid),
        .key_ready_i  (key_ready),
        .err_count_o  (cmp_errors)
    );

    task automatic add_row(input logic [8*24-1:0] name, input int nbytes,
                           input logic [7:0] b0, input logic [7:0] b1,
                           input logic [7:0] b2, input int nfirst, input int stop_x,
                           input int budget, input int ex, input int ey, input int es,
                           input int eh, input game_state_e st);
        row_name[row_count]    = name;
        row_nbytes[row_count]  = nbytes;
        row_byte[row_count][0] = b0;
        row_byte[row_count][1] = b1;
        row_byte[row_count][2] = b2;
        row_nfirst[row_count]  = nfirst;
        row_stop_x[row_count]  = stop_x;
        row_budget[row_count]  = budget;
        row_x[row_count]       = ex;
        row_y[row_count]       = ey;
        row_score[row_count]   = es;
        row_health[row_count]  = eh;
        row_state[row_count]   = st;
        row_count = row_count + 1;
    endtask

    task automatic build_table();
        logic [7:0] br;
        br = `KEY_BREAK;
        add_row("reset_idle", 0, 0, 0, 0, 0, -1, 50, 4, 192, 0, 3, GAME_IDLE);
        add_row("idle_keys", 3, `KEY_D, br, `KEY_D, 3, -1, 60, 4, 192, 0, 3, GAME_IDLE);
        add_row("restart", 1, `KEY_R, 0, 0, 1, -1, 60, 4, 192, 0, 3, GAME_PLAY);
        // wall at x 80, so the right edge stops at 72
        add_row("walk_to_wall", 1, `KEY_D, 0, 0, 1, -1, 400, 72, 192, 2, 3, GAME_PLAY);
        add_row("release_d", 2, br, `KEY_D, 0, 2, -1, 60, 72, 192, 2, 3, GAME_PLAY);
        add_row("walk_back", 1, `KEY_A, 0, 0, 1, -1, 400, 0, 192, 2, 3, GAME_PLAY);
        add_row("release_a", 2, br, `KEY_A, 0, 2, -1, 60, 0, 192, 2, 3, GAME_PLAY);
        add_row("jump_in_place", 3, `KEY_W, br, `KEY_W, 3, -1, 300, 0, 192, 2, 3, GAME_PLAY);
        // stop somewhere under the monster, x 33 to 47 all touch it on a jump
        add_row("walk_under_monster", 3, `KEY_D, br, `KEY_D, 1, 36, 250,
                XSKIP, 192, 2, 3, GAME_PLAY);
        add_row("monster_hit_1", 3, `KEY_W, br, `KEY_W, 3, -1, 300,
                XSAME, 192, 2, 2, GAME_PLAY);
        add_row("monster_hit_2", 3, `KEY_W, br, `KEY_W, 3, -1, 300,
                XSAME, 192, 2, 1, GAME_PLAY);
        add_row("monster_hit_3", 3, `KEY_W, br, `KEY_W, 3, -1, 300,
                XSAME, 192, 2, 0, GAME_LOSE);
        add_row("lose_ignores_keys", 3, `KEY_A, br, `KEY_A, 3, -1, 60,
                XSAME, 192, 2, 0, GAME_LOSE);
        add_row("restart_after_loss", 1, `KEY_R, 0, 0, 1, -1, 60, 4, 192, 0, 3, GAME_PLAY);
        add_row("walk_to_wall_again", 1, `KEY_D, 0, 0, 1, -1, 400, 72, 192, 2, 3, GAME_PLAY);
        // D still held, lands on the wall top and grabs the third snowflake
        add_row("jump_onto_wall", 3, `KEY_W, br, `KEY_W, 3, -1, 300,
                XSKIP, 176, 3, 3, GAME_WIN);
    endtask

    // one byte through valid/ready, entered and left 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) begin
            @(posedge clk);
            #1;
        end
        key_data  = b;
        key_valid = 1'b1;
        @(negedge clk);
        while (!key_ready) @(negedge clk);
        @(posedge clk);
        #1;
        key_valid = 1'b0;
    endtask

    task automatic run_row(input int r);
        int x_start;
        int waited;
        int stable;
        int snap;
        int prev;
        x_start = int'(player_x);
        for (int i = 0; i < row_nfirst[r]; i++) send_byte(row_byte[r][i]);
        if (row_stop_x[r] >= 0) begin
            waited = 0;
            while (int'(player_x) != row_stop_x[r] && waited < row_budget[r]) begin
                @(negedge clk);
                waited++;
            end
            if (waited >= row_budget[r]) begin
                $display("%0s: player never reached x %0d", row_name[r], row_stop_x[r]);
                other_errors++;
            end
            @(posedge clk);
            #1;
        end
        for (int i = row_nfirst[r]; i < row_nbytes[r]; i++) send_byte(row_byte[r][i]);
        // wait for the outputs to stop changing
        stable = 0;
        waited = 0;
        prev = {player_x, player_y, score, health, game_state};
        while (stable < SETTLE && waited < row_budget[r]) begin
            @(negedge clk);
            waited++;
            snap = {player_x, player_y, score, health, game_state};
            if (snap == prev) begin
                stable++;
            end else begin
                stable = 0;
                prev = snap;
            end
        end
        if (stable < SETTLE) begin
            $display("%0s: outputs still changing after %0d cycles", row_name[r], waited);
            other_errors++;
        end
        @(posedge clk);
        #1;
        cur_name    = row_name[r];
        cur_check_x = (row_x[r] != XSKIP);
        cur_x       = (row_x[r] == XSAME) ? x_start : row_x[r];
        cur_y       = row_y[r];
        cur_score   = row_score[r];
        cur_health  = row_health[r];
        cur_state   = row_state[r];
        check_req   = 1'b1;
        @(posedge clk);
        #1;
        check_req = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the run did not finish", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        key_data     = 8'h00;
        key_valid    = 1'b0;
        check_req    = 1'b0;
        cur_name     = '0;
        cur_check_x  = 1'b0;
        cur_x        = 0;
        cur_y        = 0;
        cur_score    = 0;
        cur_health   = 0;
        cur_state    = GAME_IDLE;
        other_errors = 0;
        cycles       = 0;
        row_count    = 0;
        seed         = 32'hf294_71a7;
        cycle_limit  = 1000;
        build_table();
        // row budgets plus room for byte transfers and settling
        for (int r = 0; r < row_count; r++) cycle_limit += row_budget[r] + 80;
        @(posedge rst_n);
        @(posedge clk);
        #1;
        for (int r = 0; r < row_count; r++) run_row(r);
        repeat (2) @(posedge clk);
        $display("errors: %0d compare, %0d other", cmp_errors, other_errors);
        if (cmp_errors == 0 && other_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+include
hdl/game_pkg.sv
hdl/key_decoder.sv
hdl/level_map.sv
hdl/player_motion.sv
hdl/pickup_tracker.sv
hdl/game_status.sv
hdl/platform_game_top.sv
tests/tb_clock.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/bin/sh
# build the Verilator model, run it, and pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -Iinclude \
    -f all.f --top-module tb_top -Mdir obj_dir -o sim_tb \
    && ./obj_dir/sim_tb | tee /dev/stderr | grep -q "PASS: all tests" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
